// ==== design/tg_mem_pkg.sv ====
`default_nettype none

package tg_mem_pkg;

   ////////////////////////////////////////
   // Memory port types
   ////////////////////////////////////////

   // Word address on the memory port
   typedef logic [15:0] mem_addr_t;

   // One memory data word
   typedef logic [31:0] mem_data_t;

   // Data LFSR state, one bit per data bit
   typedef logic [31:0] lfsr_state_t;

   // Feedback taps at bits 31, 21, 1 and 0
   // Next state is state << 1 with bit 0 = XOR of the tapped bits
   localparam lfsr_state_t lfsr_taps = 32'h8020_0003;

endpackage

`default_nettype wire

// ==== design/tg_ctrl_pkg.sv ====
`default_nettype none

package tg_ctrl_pkg;

   ////////////////////////////////////////
   // APB and configuration types
   ////////////////////////////////////////

   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // Words per loop, 1 to 256
   typedef logic [8:0]  word_count_t;

   // Loops per run, zero runs until stopped
   typedef logic [15:0] loop_count_t;

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   localparam apb_addr_t reg_ctrl      = 8'h00;
   localparam apb_addr_t reg_status    = 8'h04;
   localparam apb_addr_t reg_base      = 8'h08;
   localparam apb_addr_t reg_count     = 8'h0C;
   localparam apb_addr_t reg_seed      = 8'h10;
   localparam apb_addr_t reg_loops     = 8'h14;
   localparam apb_addr_t reg_fail_addr = 8'h18;
   localparam apb_addr_t reg_pnf       = 8'h1C;

   // Control bits, write-one pulses
   localparam int ctrl_start_bit = 0;
   localparam int ctrl_stop_bit  = 1;

   // Status bits
   localparam int status_busy_bit = 0;
   localparam int status_done_bit = 1;
   localparam int status_pass_bit = 2;
   localparam int status_fail_bit = 3;

   // Stage sequencer states
   typedef enum logic [2:0] {
      seq_idle,
      seq_write,
      seq_read,
      seq_drain,
      seq_done
   } seq_state_t;

endpackage

`default_nettype wire

// ==== design/tg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module tg_regs
   import tg_mem_pkg::*, tg_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,

   // APB slave
   input  apb_addr_t   paddr,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  apb_data_t   pwdata,
   output apb_data_t   prdata,
   output logic        pready,
   output logic        pslverr,

   // Status from the generator
   input  logic        busy,
   input  logic        done,
   input  mem_data_t   pnf,
   input  logic        fail_seen,
   input  mem_addr_t   first_fail_addr,

   // Control and configuration
   output logic        start_pulse,
   output logic        stop_pulse,
   output mem_addr_t   cfg_base,
   output word_count_t cfg_count,
   output lfsr_state_t cfg_seed,
   output loop_count_t cfg_loops,
   output logic        pass,
   output logic        fail
);

   logic access;
   logic wr_access;
   logic mapped;

   // Access phase of a transfer, no wait states
   assign access    = psel & penable;
   assign wr_access = access & pwrite;
   assign pready    = 1'b1;

   ////////////////////////////////////////
   // Result pins
   ////////////////////////////////////////

   assign pass = done & (&pnf);
   // Infinite mode flags the first mismatch without waiting for done
   assign fail = fail_seen & (done | (cfg_loops == '0));

   ////////////////////////////////////////
   // Read decode
   ////////////////////////////////////////

   always_comb
   begin
      mapped = 1'b1;
      prdata = '0;
      case (paddr)
         // Pulse bits read back as zero
         reg_ctrl      : prdata = '0;
         reg_status    :
         begin
            prdata[status_busy_bit] = busy;
            prdata[status_done_bit] = done;
            prdata[status_pass_bit] = pass;
            prdata[status_fail_bit] = fail;
         end
         reg_base      : prdata = apb_data_t'(cfg_base);
         reg_count     : prdata = apb_data_t'(cfg_count);
         reg_seed      : prdata = apb_data_t'(cfg_seed);
         reg_loops     : prdata = apb_data_t'(cfg_loops);
         reg_fail_addr : prdata = apb_data_t'(first_fail_addr);
         reg_pnf       : prdata = apb_data_t'(pnf);
         default       : mapped = 1'b0;
      endcase
   end

   assign pslverr = access & ~mapped;

   // Control pulses, one cycle after the access edge
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         start_pulse <= 1'b0;
         stop_pulse  <= 1'b0;
      end
      else
      begin
         start_pulse <= wr_access && (paddr == reg_ctrl) && pwdata[ctrl_start_bit];
         stop_pulse  <= wr_access && (paddr == reg_ctrl) && pwdata[ctrl_stop_bit];
      end
   end

   // Configuration is frozen while a run is active
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         cfg_base  <= '0;
         cfg_count <= word_count_t'(1);
         cfg_seed  <= lfsr_state_t'(1);
         cfg_loops <= loop_count_t'(1);
      end
      else if (wr_access && !busy)
      begin
         case (paddr)
            reg_base  : cfg_base  <= mem_addr_t'(pwdata);
            reg_count : cfg_count <= word_count_t'(pwdata);
            // All-zero seed would lock the LFSR
            reg_seed  : cfg_seed  <= (pwdata == '0) ? lfsr_state_t'(1) : lfsr_state_t'(pwdata);
            reg_loops : cfg_loops <= loop_count_t'(pwdata);
            default   : ;
         endcase
      end
   end

   // An error response only ends a transfer that went through its setup phase
   assert property (@(posedge clk) disable iff (!reset_n)
      pslverr |-> penable && $past(psel && !penable));

endmodule

`default_nettype wire

// ==== design/tg_data_lfsr.sv ====
`timescale 1ns/100ps
`default_nettype none

module tg_data_lfsr
   import tg_mem_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   input  logic        load,
   input  lfsr_state_t seed,
   input  logic        step,
   output mem_data_t   value
);

   lfsr_state_t state;
   logic        feedback;

   // XOR of the tapped bits becomes the new bit 0
   assign feedback = ^(state & lfsr_taps);

   ////////////////////////////////////////
   // State register
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         state <= lfsr_state_t'(1);
      else if (load)
         state <= seed;
      else if (step)
         state <= {state[$bits(lfsr_state_t)-2:0], feedback};
   end

   // Current state is the data word
   assign value = mem_data_t'(state);

endmodule

`default_nettype wire

// ==== design/tg_driver_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module tg_driver_fsm
   import tg_mem_pkg::*, tg_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,

   // Control and configuration
   input  logic        start_pulse,
   input  logic        stop_pulse,
   input  mem_addr_t   cfg_base,
   input  word_count_t cfg_count,
   input  loop_count_t cfg_loops,

   // Memory master port
   input  logic        mem_ready,
   output logic        mem_write,
   output logic        mem_read,
   output mem_addr_t   mem_addr,
   output mem_data_t   mem_wdata,

   // From compare and write LFSR
   input  logic        reads_idle,
   input  mem_data_t   wdata,

   // Status and LFSR control
   output logic        busy,
   output logic        done,
   output logic        write_step,
   output logic        lfsr_load
);

   seq_state_t  state;
   word_count_t word_idx;
   loop_count_t loop_cnt;
   logic        stop_req;
   logic        cmd_accept;
   logic        last_word;
   logic        last_loop;
   logic        end_run;

   ////////////////////////////////////////
   // Command outputs decoded from state
   ////////////////////////////////////////

   assign mem_write = (state == seq_write);
   assign mem_read  = (state == seq_read);
   // Sequential addressing, wraps at 16 bits
   assign mem_addr  = cfg_base + mem_addr_t'(word_idx);
   assign mem_wdata = wdata;

   assign busy = state inside {seq_write, seq_read, seq_drain};
   assign done = (state == seq_done);

   assign cmd_accept = (mem_write | mem_read) & mem_ready;
   assign write_step = mem_write & mem_ready;
   // Both LFSRs restart from the seed on an accepted start
   assign lfsr_load  = start_pulse & ~busy;

   assign last_word = (word_idx == cfg_count - word_count_t'(1));
   // Zero loops never reaches the last loop
   assign last_loop = (cfg_loops != '0) && (loop_cnt == cfg_loops - loop_count_t'(1));
   assign end_run   = stop_req | stop_pulse;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state    <= seq_idle;
         word_idx <= '0;
         loop_cnt <= '0;
         stop_req <= 1'b0;
      end
      else
      begin
         // Stop is held until the current command is taken
         if (stop_pulse && busy)
            stop_req <= 1'b1;

         case (state)
            seq_idle, seq_done:
               if (start_pulse)
               begin
                  state    <= seq_write;
                  word_idx <= '0;
                  loop_cnt <= '0;
                  stop_req <= 1'b0;
               end

            seq_write:
               if (cmd_accept)
               begin
                  word_idx <= word_idx + word_count_t'(1);
                  if (end_run)
                     state <= seq_drain;
                  else if (last_word)
                  begin
                     state    <= seq_read;
                     word_idx <= '0;
                  end
               end

            // Reads go out back to back, data is not awaited here
            seq_read:
               if (cmd_accept)
               begin
                  word_idx <= word_idx + word_count_t'(1);
                  if (end_run || last_word)
                     state <= seq_drain;
               end

            // Wait for all read data before the next loop or the end
            seq_drain:
               if (reads_idle)
               begin
                  if (end_run || last_loop)
                     state <= seq_done;
                  else
                  begin
                     state    <= seq_write;
                     word_idx <= '0;
                     loop_cnt <= loop_cnt + loop_count_t'(1);
                  end
               end

            default: state <= seq_idle;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset_n)
      !(mem_write && mem_read));

   // A stalled command holds until the memory takes it
   assert property (@(posedge clk) disable iff (!reset_n)
      (mem_write || mem_read) && !mem_ready |=>
         $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_write) && $stable(mem_read));

endmodule

`default_nettype wire

// ==== design/tg_read_compare.sv ====
`timescale 1ns/100ps
`default_nettype none

module tg_read_compare
   import tg_mem_pkg::*, tg_ctrl_pkg::*;
(
   input  logic        clk,
   input  logic        reset_n,
   input  logic        lfsr_load,
   input  mem_addr_t   cfg_base,
   input  word_count_t cfg_count,

   // Memory port, observed
   input  logic        mem_read,
   input  logic        mem_ready,
   input  logic        mem_rdata_valid,
   input  mem_data_t   mem_rdata,

   // Expected data LFSR
   input  mem_data_t   expected,
   output logic        expect_step,

   // Results
   output mem_data_t   pnf,
   output logic        fail_seen,
   output mem_addr_t   first_fail_addr,
   output logic        reads_idle
);

   word_count_t outstanding;
   word_count_t rd_index;
   mem_data_t   mismatch;
   logic        rd_accept;
   logic        any_mismatch;

   assign rd_accept    = mem_read & mem_ready;
   assign expect_step  = mem_rdata_valid;
   assign mismatch     = mem_rdata ^ expected;
   assign any_mismatch = mem_rdata_valid & (|mismatch);
   assign reads_idle   = (outstanding == '0);

   ////////////////////////////////////////
   // Outstanding read count
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         outstanding <= '0;
      else
         case ({rd_accept, mem_rdata_valid})
            2'b10   : outstanding <= outstanding + word_count_t'(1);
            2'b01   : outstanding <= outstanding - word_count_t'(1);
            default : ;
         endcase
   end

   ////////////////////////////////////////
   // Data check
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!reset_n || lfsr_load)
      begin
         pnf             <= '1;
         fail_seen       <= 1'b0;
         first_fail_addr <= '0;
         rd_index        <= '0;
      end
      else if (mem_rdata_valid)
      begin
         // Sticky per-bit pass/not-fail
         pnf <= pnf & ~mismatch;
         if (any_mismatch && !fail_seen)
         begin
            fail_seen       <= 1'b1;
            first_fail_addr <= cfg_base + mem_addr_t'(rd_index);
         end
         // Index restarts at base for every loop
         if (rd_index == cfg_count - word_count_t'(1))
            rd_index <= '0;
         else
            rd_index <= rd_index + word_count_t'(1);
      end
   end

   // Memory returns nothing that was not asked for
   assert property (@(posedge clk) disable iff (!reset_n)
      mem_rdata_valid |-> !reads_idle);

endmodule

`default_nettype wire

// ==== design/tg_driver_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tg_driver_top
   import tg_mem_pkg::*, tg_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,

   // APB configuration slave
   input  apb_addr_t paddr,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,

   // Memory master port
   output logic      mem_write,
   output logic      mem_read,
   output mem_addr_t mem_addr,
   output mem_data_t mem_wdata,
   input  logic      mem_ready,
   input  logic      mem_rdata_valid,
   input  mem_data_t mem_rdata,

   // Result pins
   output logic      pass,
   output logic      fail
);

   ////////////////////////////////////////
   // Internal connections
   ////////////////////////////////////////

   // Configuration and control
   logic        start_pulse;
   logic        stop_pulse;
   mem_addr_t   cfg_base;
   word_count_t cfg_count;
   lfsr_state_t cfg_seed;
   loop_count_t cfg_loops;

   // Sequencer status
   logic        busy;
   logic        done;
   logic        write_step;
   logic        lfsr_load;

   // Compare results
   mem_data_t   pnf;
   logic        fail_seen;
   mem_addr_t   first_fail_addr;
   logic        reads_idle;
   logic        expect_step;

   // LFSR outputs
   mem_data_t   wdata;
   mem_data_t   expected;

   tg_regs regs0 (
      .clk             (clk),
      .reset_n         (reset_n),
      .paddr           (paddr),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .pready          (pready),
      .pslverr         (pslverr),
      .busy            (busy),
      .done            (done),
      .pnf             (pnf),
      .fail_seen       (fail_seen),
      .first_fail_addr (first_fail_addr),
      .start_pulse     (start_pulse),
      .stop_pulse      (stop_pulse),
      .cfg_base        (cfg_base),
      .cfg_count       (cfg_count),
      .cfg_seed        (cfg_seed),
      .cfg_loops       (cfg_loops),
      .pass            (pass),
      .fail            (fail)
   );

   tg_driver_fsm fsm0 (
      .clk         (clk),
      .reset_n     (reset_n),
      .start_pulse (start_pulse),
      .stop_pulse  (stop_pulse),
      .cfg_base    (cfg_base),
      .cfg_count   (cfg_count),
      .cfg_loops   (cfg_loops),
      .mem_ready   (mem_ready),
      .mem_write   (mem_write),
      .mem_read    (mem_read),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .reads_idle  (reads_idle),
      .wdata       (wdata),
      .busy        (busy),
      .done        (done),
      .write_step  (write_step),
      .lfsr_load   (lfsr_load)
   );

   // Write data, stepped on each accepted write
   tg_data_lfsr wdata_lfsr (
      .clk     (clk),
      .reset_n (reset_n),
      .load    (lfsr_load),
      .seed    (cfg_seed),
      .step    (write_step),
      .value   (wdata)
   );

   // Expected data, stepped on each returned word
   tg_data_lfsr expect_lfsr (
      .clk     (clk),
      .reset_n (reset_n),
      .load    (lfsr_load),
      .seed    (cfg_seed),
      .step    (expect_step),
      .value   (expected)
   );

   tg_read_compare compare0 (
      .clk             (clk),
      .reset_n         (reset_n),
      .lfsr_load       (lfsr_load),
      .cfg_base        (cfg_base),
      .cfg_count       (cfg_count),
      .mem_read        (mem_read),
      .mem_ready       (mem_ready),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_rdata       (mem_rdata),
      .expected        (expected),
      .expect_step     (expect_step),
      .pnf             (pnf),
      .fail_seen       (fail_seen),
      .first_fail_addr (first_fail_addr),
      .reads_idle      (reads_idle)
   );

endmodule

`default_nettype wire

// ==== tests/tg_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module tg_mem_model
   import tg_mem_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,

   // Memory slave port
   input  logic       mem_write,
   input  logic       mem_read,
   input  mem_addr_t  mem_addr,
   input  mem_data_t  mem_wdata,
   output logic       mem_ready,
   output logic       mem_rdata_valid,
   output mem_data_t  mem_rdata,

   // Test controls
   input  logic       stall_en,
   input  logic       fault_en,
   input  mem_addr_t  fault_addr,
   input  logic [4:0] fault_bit
);

   // Full 16-bit word space
   mem_data_t mem [0:65535];

   // Pending read data with the cycle it is due
   mem_data_t rd_data_q [$];
   int        rd_due_q [$];

   integer    seed;
   int        cycle;
   int        last_due;
   int        lat;
   int        due;
   int        a;
   logic      take_wr;
   logic      take_rd;
   mem_addr_t cmd_addr;
   mem_data_t cmd_wdata;
   mem_data_t wr_word;

   initial
   begin
      seed            = 32'h98dbe09c;
      mem_ready       = 1'b1;
      mem_rdata_valid = 1'b0;
      mem_rdata       = '0;
      cycle           = 0;
      last_due        = 0;
      take_wr         = 1'b0;
      take_rd         = 1'b0;
      // Fill pattern tied to the full address
      for (a = 0; a < 65536; a++)
         mem[a] = {a[15:0], ~a[15:0]};

      forever
      begin
         // Command lines are steady here, ahead of the next edge
         @(negedge clk);
         take_wr   = mem_write & mem_ready & reset_n;
         take_rd   = mem_read & mem_ready & reset_n;
         cmd_addr  = mem_addr;
         cmd_wdata = mem_wdata;

         @(posedge clk);
         #1;
         cycle++;
         if (!reset_n)
         begin
            rd_data_q.delete();
            rd_due_q.delete();
            mem_rdata_valid = 1'b0;
            mem_ready       = 1'b1;
         end
         else
         begin
            // Stuck-low bit applies to the stored word
            if (take_wr)
            begin
               wr_word = cmd_wdata;
               if (fault_en && cmd_addr == fault_addr)
                  wr_word[fault_bit] = 1'b0;
               mem[cmd_addr] = wr_word;
            end

            // Latency 1 to 4, kept in order at one word per cycle
            if (take_rd)
            begin
               lat = 1 + ($random(seed) & 3);
               due = cycle + lat;
               if (due <= last_due)
                  due = last_due + 1;
               last_due = due;
               rd_data_q.push_back(mem[cmd_addr]);
               rd_due_q.push_back(due);
            end

            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle)
            begin
               mem_rdata_valid = 1'b1;
               mem_rdata       = rd_data_q.pop_front();
               due             = rd_due_q.pop_front();
            end
            else
               mem_rdata_valid = 1'b0;

            // Ready low about one cycle in four
            mem_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tests/tb_tg_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_tg_driver
   import tg_mem_pkg::*, tg_ctrl_pkg::*;
();

   localparam int clk_half     = 20;
   localparam int reset_cycles = 16;
   localparam int apb_cycles   = 3;
   localparam int apb_accesses = 60;
   localparam int max_polls    = 200;

   logic        clk = 1'b0;
   logic        reset_n;

   // APB
   apb_addr_t   paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_data_t   pwdata;
   apb_data_t   prdata;
   logic        pready;
   logic        pslverr;

   // Memory port
   logic        mem_write;
   logic        mem_read;
   mem_addr_t   mem_addr;
   mem_data_t   mem_wdata;
   logic        mem_ready;
   logic        mem_rdata_valid;
   mem_data_t   mem_rdata;

   logic        pass;
   logic        fail;

   // Memory model controls
   logic        stall_en;
   logic        fault_en;
   mem_addr_t   fault_addr;
   logic [4:0]  fault_bit;

   int          errors;
   int          checks;

   always #clk_half clk = ~clk;

   tg_driver_top dut0 (
      .clk             (clk),
      .reset_n         (reset_n),
      .paddr           (paddr),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .pready          (pready),
      .pslverr         (pslverr),
      .mem_write       (mem_write),
      .mem_read        (mem_read),
      .mem_addr        (mem_addr),
      .mem_wdata       (mem_wdata),
      .mem_ready       (mem_ready),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_rdata       (mem_rdata),
      .pass            (pass),
      .fail            (fail)
   );

   tg_mem_model model0 (
      .clk             (clk),
      .reset_n         (reset_n),
      .mem_write       (mem_write),
      .mem_read        (mem_read),
      .mem_addr        (mem_addr),
      .mem_wdata       (mem_wdata),
      .mem_ready       (mem_ready),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_rdata       (mem_rdata),
      .stall_en        (stall_en),
      .fault_en        (fault_en),
      .fault_addr      (fault_addr),
      .fault_bit       (fault_bit)
   );

   ////////////////////////////////////////
   // Checks and reference model
   ////////////////////////////////////////

   task automatic check(input string test, input string item,
                        input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      assert (actual === expected)
      else
      begin
         errors++;
         $display("mismatch %s %s: expected %h, actual %h", test, item, expected, actual);
      end
   endtask

   task automatic check_true(input string test, input logic cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         errors++;
         $display("%s: %s", test, what);
      end
   endtask

   // Shift left with the new bit 0 from bits 31, 21, 1 and 0
   task automatic lfsr_step(inout lfsr_state_t s);
      s = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endtask

   task automatic lfsr_advance(inout lfsr_state_t s, input int steps);
      int i;
      for (i = 0; i < steps; i++)
         lfsr_step(s);
   endtask

   function automatic apb_data_t expected_status(input logic busy, input logic done,
                                                 input logic ok, input logic bad);
      apb_data_t s;
      s = '0;
      s[status_busy_bit] = busy;
      s[status_done_bit] = done;
      s[status_pass_bit] = ok;
      s[status_fail_bit] = bad;
      return s;
   endfunction

   ////////////////////////////////////////
   // APB access
   ////////////////////////////////////////

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      while (!pready)
         @(negedge clk);
      // Access edge
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
                           output logic slverr);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(posedge clk);
      #1;
      penable = 1'b1;
      // Read data and error sampled mid access phase
      @(negedge clk);
      while (!pready)
         @(negedge clk);
      data   = prdata;
      slverr = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic configure(input mem_addr_t base, input int count,
                            input lfsr_state_t seed, input int loops);
      apb_write(reg_base, apb_data_t'(base));
      apb_write(reg_count, apb_data_t'(count));
      apb_write(reg_seed, seed);
      apb_write(reg_loops, apb_data_t'(loops));
   endtask

   // Poll status until done with a bounded number of reads
   task automatic wait_done(input string test);
      apb_data_t status;
      logic      err;
      int        polls;
      status = '0;
      polls  = 0;
      while (!status[status_done_bit] && polls < max_polls)
      begin
         apb_read(reg_status, status, err);
         polls++;
      end
      check_true(test, status[status_done_bit], "done did not rise before the poll limit");
   endtask

   // Memory contents against the reference sequence with the address wrapping at 16 bits
   task automatic check_block(input string test, input mem_addr_t base, input int count,
                              input lfsr_state_t start);
      lfsr_state_t s;
      mem_addr_t   a;
      int          i;
      s = start;
      for (i = 0; i < count; i++)
      begin
         a = base + mem_addr_t'(i);
         check(test, $sformatf("word at %h", a), s, model0.mem[a]);
         lfsr_step(s);
      end
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic test_register_access();
      apb_data_t rd;
      logic      err;
      apb_read(reg_status, rd, err);
      check("register_access", "reset status", 32'h0, rd);
      apb_read(reg_pnf, rd, err);
      check("register_access", "reset pnf", 32'hFFFF_FFFF, rd);
      apb_read(reg_fail_addr, rd, err);
      check("register_access", "reset fail_addr", 32'h0, rd);
      check("register_access", "pslverr on mapped read", 32'h0, 32'(err));

      configure(16'h1234, 200, 32'hCAFE_F00D, 7);
      apb_read(reg_base, rd, err);
      check("register_access", "base", 32'h0000_1234, rd);
      apb_read(reg_count, rd, err);
      check("register_access", "count", 32'd200, rd);
      apb_read(reg_seed, rd, err);
      check("register_access", "seed", 32'hCAFE_F00D, rd);
      apb_read(reg_loops, rd, err);
      check("register_access", "loops", 32'd7, rd);

      // Zero seed is stored as one
      apb_write(reg_seed, 32'h0);
      apb_read(reg_seed, rd, err);
      check("register_access", "zero seed", 32'd1, rd);

      apb_read(8'h40, rd, err);
      check("register_access", "unmapped data", 32'h0, rd);
      check("register_access", "unmapped pslverr", 32'd1, 32'(err));
   endtask

   task automatic test_clean_run();
      apb_data_t rd;
      logic      err;
      stall_en = 1'b0;
      configure(16'hFFF8, 16, 32'h1357_9BDF, 1);
      apb_write(reg_ctrl, 32'h1);
      wait_done("clean_run");
      check_block("clean_run", 16'hFFF8, 16, 32'h1357_9BDF);
      @(negedge clk);
      check("clean_run", "pass pin", 32'd1, 32'(pass));
      check("clean_run", "fail pin", 32'd0, 32'(fail));
      apb_read(reg_status, rd, err);
      check("clean_run", "status", expected_status(0, 1, 1, 0), rd);
      apb_read(reg_pnf, rd, err);
      check("clean_run", "pnf", 32'hFFFF_FFFF, rd);
   endtask

   task automatic test_multi_loop();
      lfsr_state_t s;
      apb_data_t   rd;
      logic        err;
      stall_en = 1'b1;
      configure(16'h0100, 8, 32'h89AB_CDEF, 3);
      apb_write(reg_ctrl, 32'h1);
      wait_done("multi_loop");
      // Third block follows two loops of eight words
      s = 32'h89AB_CDEF;
      lfsr_advance(s, 16);
      check_block("multi_loop", 16'h0100, 8, s);
      @(negedge clk);
      check("multi_loop", "pass pin", 32'd1, 32'(pass));
      apb_read(reg_pnf, rd, err);
      check("multi_loop", "pnf", 32'hFFFF_FFFF, rd);
   endtask

   task automatic test_fault();
      apb_data_t   rd;
      logic        err;
      // Word three from seed 0xA5 is 0x0000052D with bit 5 set
      fault_en   = 1'b1;
      fault_addr = 16'h2003;
      fault_bit  = 5'd5;
      configure(16'h2000, 8, 32'h0000_00A5, 1);
      apb_write(reg_ctrl, 32'h1);
      wait_done("fault");
      @(negedge clk);
      check("fault", "fail pin", 32'd1, 32'(fail));
      check("fault", "pass pin", 32'd0, 32'(pass));
      apb_read(reg_fail_addr, rd, err);
      check("fault", "fail_addr", 32'h0000_2003, rd);
      apb_read(reg_pnf, rd, err);
      check("fault", "pnf", ~(32'd1 << 5), rd);
      fault_en = 1'b0;
   endtask

   task automatic test_infinite();
      apb_data_t   rd;
      logic        err;
      logic        seen;
      int          cycles;
      // Word one from seed 0xA5 is 0x0000014B with bit 1 set
      fault_en   = 1'b1;
      fault_addr = 16'h3001;
      fault_bit  = 5'd1;
      configure(16'h3000, 4, 32'h0000_00A5, 0);
      apb_write(reg_ctrl, 32'h1);

      // Fail pin rises while the run goes on
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < max_polls * apb_cycles)
      begin
         @(negedge clk);
         seen = fail;
         cycles++;
      end
      check_true("infinite", seen, "fail pin did not rise before stop");
      apb_read(reg_status, rd, err);
      check("infinite", "busy before stop", 32'd1, 32'(rd[status_busy_bit]));

      apb_write(reg_ctrl, 32'h2);
      wait_done("infinite");
      apb_read(reg_status, rd, err);
      check("infinite", "status after stop", expected_status(0, 1, 0, 1), rd);
      apb_read(reg_fail_addr, rd, err);
      check("infinite", "fail_addr", 32'h0000_3001, rd);
      fault_en = 1'b0;
   endtask

   ////////////////////////////////////////
   // Run control
   ////////////////////////////////////////

   // Worst case of one run with each command stalled for up to four cycles
   function automatic int run_cycles(input int words, input int loops);
      return loops * (2 * words * 4 + 8);
   endfunction

   initial
   begin
      errors     = 0;
      checks     = 0;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      stall_en   = 1'b0;
      fault_en   = 1'b0;
      fault_addr = '0;
      fault_bit  = '0;
      reset_n    = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1;
      reset_n = 1'b1;

      test_register_access();
      test_clean_run();
      test_multi_loop();
      test_fault();
      test_infinite();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // Watchdog set to twice the summed worst case of all tests
   initial
   begin
      int limit;
      limit = 2 * (reset_cycles + apb_accesses * apb_cycles + run_cycles(16, 1)
                   + run_cycles(8, 3) + run_cycles(8, 1) + run_cycles(4, 4));
      repeat (limit) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", limit);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
design/tg_mem_pkg.sv
design/tg_ctrl_pkg.sv
design/tg_regs.sv
design/tg_data_lfsr.sv
design/tg_driver_fsm.sv
design/tg_read_compare.sv
design/tg_driver_top.sv
tests/tg_mem_model.sv
tests/tb_tg_driver.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_tg_driver -f sim.f -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
